// File: source/rvPkg.sv
`default_nettype none

package rvPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [2:0] aluOp_t;
    typedef logic [1:0] fwdSel_t;
    typedef logic [1:0] resultSrc_t;

    localparam aluOp_t ALU_ADD = 3'd0;
    localparam aluOp_t ALU_SUB = 3'd1;
    localparam aluOp_t ALU_AND = 3'd2;
    localparam aluOp_t ALU_OR = 3'd3;
    localparam aluOp_t ALU_XOR = 3'd4;
    localparam aluOp_t ALU_SLT = 3'd5;

    localparam fwdSel_t FWD_NONE = 2'd0;
    localparam fwdSel_t FWD_WB = 2'd1;
    localparam fwdSel_t FWD_MEM = 2'd2;

    localparam resultSrc_t RES_ALU = 2'd0;
    localparam resultSrc_t RES_MEM = 2'd1;
    localparam resultSrc_t RES_PC4 = 2'd2;

    localparam logic [6:0] OP_RTYPE = 7'b0110011;
    localparam logic [6:0] OP_ITYPE = 7'b0010011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;

    // All-zero word is a bubble
    typedef struct packed {
        logic regWrite;
        resultSrc_t resultSrc;
        logic memWrite;
        logic memRead;
        logic branch;
        logic jump;
        logic aluSrc;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t instr;
    } loadReq_t;

    typedef struct packed {
        regAddr_t rd;
        word_t value;
    } wbInfo_t;

endpackage

`default_nettype wire

// File: source/instrMemory.sv
`default_nettype none

module instrMemory #(
    parameter int IMEM_WORDS = 64
)(
    input logic clk,
    input logic run,
    input logic loadValid,
    input rvPkg::loadReq_t load,
    input rvPkg::word_t fetchPc,
    output logic loadReady,
    output rvPkg::word_t fetchInstr
);

    localparam int AW = $clog2(IMEM_WORDS);

    rvPkg::word_t mem [IMEM_WORDS];

    // Loading only while the core is stopped
    assign loadReady = ~run;

    always_ff @(posedge clk) begin
        if (loadValid && loadReady) begin
            mem[load.addr[AW-1:0]] <= load.instr;
        end
    end

    assign fetchInstr = mem[fetchPc[AW+1:2]];

endmodule

`default_nettype wire

// File: source/decodeUnit.sv
`default_nettype none

module decodeUnit (
    input rvPkg::word_t instr,
    output rvPkg::ctrl_t ctrl,
    output rvPkg::word_t imm,
    output rvPkg::regAddr_t rs1,
    output rvPkg::regAddr_t rs2,
    output rvPkg::regAddr_t rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic subBit;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign subBit = instr[30];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd = instr[11:7];

    function automatic rvPkg::aluOp_t aluFromFunct(logic [2:0] f3, logic isSub);
        case (f3)
            3'b000: return isSub ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
            3'b010: return rvPkg::ALU_SLT;
            3'b100: return rvPkg::ALU_XOR;
            3'b110: return rvPkg::ALU_OR;
            3'b111: return rvPkg::ALU_AND;
            default: return rvPkg::ALU_ADD;
        endcase
    endfunction

    always_comb begin
        ctrl = '0;
        imm = '0;
        case (opcode)
            rvPkg::OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = aluFromFunct(funct3, subBit);
            end
            rvPkg::OP_ITYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluOp = aluFromFunct(funct3, 1'b0);
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            rvPkg::OP_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.resultSrc = rvPkg::RES_MEM;
                ctrl.memRead = 1'b1;
                ctrl.aluSrc = 1'b1;
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            rvPkg::OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            rvPkg::OP_BRANCH: begin
                // beq compares by subtraction
                ctrl.branch = 1'b1;
                ctrl.aluOp = rvPkg::ALU_SUB;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rvPkg::OP_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.resultSrc = rvPkg::RES_PC4;
                ctrl.jump = 1'b1;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/regFile.sv
`default_nettype none

module regFile (
    input logic clk,
    input rvPkg::regAddr_t rs1,
    input rvPkg::regAddr_t rs2,
    input logic we,
    input rvPkg::regAddr_t wrAddr,
    input rvPkg::word_t wrData,
    input rvPkg::regAddr_t dbgAddr,
    output rvPkg::word_t rd1,
    output rvPkg::word_t rd2,
    output rvPkg::word_t dbgData
);

    rvPkg::word_t regs [32];

    // Write-through so decode sees the value retiring this cycle
    function automatic rvPkg::word_t readReg(rvPkg::regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (we && (addr == wrAddr)) begin
            return wrData;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (we && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    always_comb begin
        rd1 = readReg(rs1);
        rd2 = readReg(rs2);
        dbgData = readReg(dbgAddr);
    end

endmodule

`default_nettype wire

// File: source/executeUnit.sv
`default_nettype none

module executeUnit (
    input rvPkg::ctrl_t ctrl,
    input rvPkg::word_t rd1,
    input rvPkg::word_t rd2,
    input rvPkg::word_t imm,
    input rvPkg::word_t pc,
    input rvPkg::fwdSel_t fwdA,
    input rvPkg::fwdSel_t fwdB,
    input rvPkg::word_t memResult,
    input rvPkg::word_t wbResult,
    output rvPkg::word_t aluResult,
    output rvPkg::word_t storeData,
    output logic redirect,
    output rvPkg::word_t target
);

    rvPkg::word_t srcA, srcB;
    logic zero;

    function automatic rvPkg::word_t pickOperand(rvPkg::fwdSel_t sel, rvPkg::word_t regVal,
                                                 rvPkg::word_t memVal, rvPkg::word_t wbVal);
        case (sel)
            rvPkg::FWD_MEM: return memVal;
            rvPkg::FWD_WB: return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA = pickOperand(fwdA, rd1, memResult, wbResult);
    assign storeData = pickOperand(fwdB, rd2, memResult, wbResult);
    assign srcB = ctrl.aluSrc ? imm : storeData;

    always_comb begin
        case (ctrl.aluOp)
            rvPkg::ALU_SUB: aluResult = srcA - srcB;
            rvPkg::ALU_AND: aluResult = srcA & srcB;
            rvPkg::ALU_OR: aluResult = srcA | srcB;
            rvPkg::ALU_XOR: aluResult = srcA ^ srcB;
            rvPkg::ALU_SLT: aluResult = {31'd0, $signed(srcA) < $signed(srcB)};
            default: aluResult = srcA + srcB;
        endcase
    end

    assign zero = (aluResult == '0);
    assign target = pc + imm;
    assign redirect = ctrl.jump || (ctrl.branch && zero);

endmodule

`default_nettype wire

// File: source/hazardUnit.sv
`default_nettype none

module hazardUnit (
    input rvPkg::regAddr_t rs1E,
    input rvPkg::regAddr_t rs2E,
    input rvPkg::regAddr_t rdM,
    input rvPkg::regAddr_t rdW,
    input logic regWriteM,
    input logic regWriteW,
    input rvPkg::regAddr_t rs1D,
    input rvPkg::regAddr_t rs2D,
    input rvPkg::regAddr_t rdE,
    input logic memReadE,
    input logic redirect,
    output rvPkg::fwdSel_t fwdA,
    output rvPkg::fwdSel_t fwdB,
    output logic stall,
    output logic flush
);

    // Youngest producer wins
    function automatic rvPkg::fwdSel_t fwdFor(rvPkg::regAddr_t src);
        if (src == '0) begin
            return rvPkg::FWD_NONE;
        end else if (regWriteM && (rdM == src)) begin
            return rvPkg::FWD_MEM;
        end else if (regWriteW && (rdW == src)) begin
            return rvPkg::FWD_WB;
        end
        return rvPkg::FWD_NONE;
    endfunction

    always_comb begin
        fwdA = fwdFor(rs1E);
        fwdB = fwdFor(rs2E);
    end

    // Load result not ready until writeback
    assign stall = memReadE && (rdE != '0) && ((rdE == rs1D) || (rdE == rs2D));
    assign flush = redirect;

endmodule

`default_nettype wire

// File: source/dataMemory.sv
`default_nettype none

module dataMemory #(
    parameter int DMEM_WORDS = 64
)(
    input logic clk,
    input logic we,
    input rvPkg::word_t addr,
    input rvPkg::word_t wrData,
    output rvPkg::word_t rdData
);

    localparam int AW = $clog2(DMEM_WORDS);

    rvPkg::word_t mem [DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr[AW+1:2]] <= wrData;
        end
    end

    // Byte offset ignored, word access only
    assign rdData = mem[addr[AW+1:2]];

endmodule

`default_nettype wire

// File: source/corePipeline.sv
`default_nettype none

module corePipeline #(
    parameter int DMEM_WORDS = 64
)(
    input logic clk,
    input logic rstN,
    input logic run,
    input rvPkg::word_t fetchInstr,
    input rvPkg::regAddr_t dbgAddr,
    output rvPkg::word_t fetchPc,
    output logic wbValid,
    output rvPkg::wbInfo_t wb,
    output rvPkg::word_t dbgData
);

    logic clear;
    rvPkg::word_t pcF;

    // Fetch/decode
    rvPkg::word_t fdInstr, fdPc;
    rvPkg::ctrl_t ctrlD;
    rvPkg::word_t immD, rd1D, rd2D;
    rvPkg::regAddr_t rs1D, rs2D, rdD;

    // Decode/execute
    rvPkg::ctrl_t deCtrl;
    rvPkg::word_t deRd1, deRd2, deImm, dePc;
    rvPkg::regAddr_t deRs1, deRs2, deRd;
    rvPkg::word_t aluResultE, storeDataE, target;
    logic redirect;

    // Execute/memory
    rvPkg::ctrl_t emCtrl;
    rvPkg::word_t emAlu, emStore, emPc4;
    rvPkg::regAddr_t emRd;
    rvPkg::word_t memRdData;

    // Memory/writeback
    rvPkg::ctrl_t mwCtrl;
    rvPkg::word_t mwAlu, mwRead, mwPc4;
    rvPkg::regAddr_t mwRd;
    rvPkg::word_t wbResult;

    rvPkg::fwdSel_t fwdA, fwdB;
    logic stall, flush;

    // Stopped core behaves as if in reset
    assign clear = !rstN || !run;
    assign fetchPc = pcF;

    always_ff @(posedge clk) begin
        if (clear) begin
            pcF <= '0;
        end else if (redirect) begin
            pcF <= target;
        end else if (!stall) begin
            pcF <= pcF + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (clear || flush) begin
            fdInstr <= '0;
        end else if (!stall) begin
            fdInstr <= fetchInstr;
            fdPc <= pcF;
        end
    end

    decodeUnit i_decodeUnit (
        .instr(fdInstr),
        .ctrl(ctrlD),
        .imm(immD),
        .rs1(rs1D),
        .rs2(rs2D),
        .rd(rdD)
    );

    regFile i_regFile (
        .clk(clk),
        .rs1(rs1D),
        .rs2(rs2D),
        .we(mwCtrl.regWrite),
        .wrAddr(mwRd),
        .wrData(wbResult),
        .dbgAddr(dbgAddr),
        .rd1(rd1D),
        .rd2(rd2D),
        .dbgData(dbgData)
    );

    always_ff @(posedge clk) begin
        if (clear || flush || stall) begin
            deCtrl <= '0;
        end else begin
            deCtrl <= ctrlD;
        end
    end

    always_ff @(posedge clk) begin
        deRd1 <= rd1D;
        deRd2 <= rd2D;
        deImm <= immD;
        dePc <= fdPc;
        deRs1 <= rs1D;
        deRs2 <= rs2D;
        deRd <= rdD;
    end

    executeUnit i_executeUnit (
        .ctrl(deCtrl),
        .rd1(deRd1),
        .rd2(deRd2),
        .imm(deImm),
        .pc(dePc),
        .fwdA(fwdA),
        .fwdB(fwdB),
        .memResult(emAlu),
        .wbResult(wbResult),
        .aluResult(aluResultE),
        .storeData(storeDataE),
        .redirect(redirect),
        .target(target)
    );

    hazardUnit i_hazardUnit (
        .rs1E(deRs1),
        .rs2E(deRs2),
        .rdM(emRd),
        .rdW(mwRd),
        .regWriteM(emCtrl.regWrite),
        .regWriteW(mwCtrl.regWrite),
        .rs1D(rs1D),
        .rs2D(rs2D),
        .rdE(deRd),
        .memReadE(deCtrl.memRead),
        .redirect(redirect),
        .fwdA(fwdA),
        .fwdB(fwdB),
        .stall(stall),
        .flush(flush)
    );

    always_ff @(posedge clk) begin
        if (clear) begin
            emCtrl <= '0;
            mwCtrl <= '0;
        end else begin
            emCtrl <= deCtrl;
            mwCtrl <= emCtrl;
        end
    end

    always_ff @(posedge clk) begin
        emAlu <= aluResultE;
        emStore <= storeDataE;
        emPc4 <= dePc + 32'd4;
        emRd <= deRd;
        mwAlu <= emAlu;
        mwRead <= memRdData;
        mwPc4 <= emPc4;
        mwRd <= emRd;
    end

    dataMemory #(
        .DMEM_WORDS(DMEM_WORDS)
    ) i_dataMemory (
        .clk(clk),
        .we(emCtrl.memWrite),
        .addr(emAlu),
        .wrData(emStore),
        .rdData(memRdData)
    );

    always_comb begin
        case (mwCtrl.resultSrc)
            rvPkg::RES_MEM: wbResult = mwRead;
            rvPkg::RES_PC4: wbResult = mwPc4;
            default: wbResult = mwAlu;
        endcase
    end

    // Writes to x0 retire silently
    assign wbValid = mwCtrl.regWrite && (mwRd != '0);
    assign wb.rd = mwRd;
    assign wb.value = wbResult;

endmodule

`default_nettype wire

// File: source/ptop.sv
`default_nettype none

module ptop #(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 64
)(
    input logic clk,
    input logic rstN,
    input logic run,
    input logic loadValid,
    output logic loadReady,
    input rvPkg::loadReq_t load,
    output logic wbValid,
    output rvPkg::wbInfo_t wb,
    input rvPkg::regAddr_t dbgAddr,
    output rvPkg::word_t dbgData
);

    rvPkg::word_t fetchPc;
    rvPkg::word_t fetchInstr;

    instrMemory #(
        .IMEM_WORDS(IMEM_WORDS)
    ) i_instrMemory (
        .clk(clk),
        .run(run),
        .loadValid(loadValid),
        .load(load),
        .fetchPc(fetchPc),
        .loadReady(loadReady),
        .fetchInstr(fetchInstr)
    );

    corePipeline #(
        .DMEM_WORDS(DMEM_WORDS)
    ) i_corePipeline (
        .clk(clk),
        .rstN(rstN),
        .run(run),
        .fetchInstr(fetchInstr),
        .dbgAddr(dbgAddr),
        .fetchPc(fetchPc),
        .wbValid(wbValid),
        .wb(wb),
        .dbgData(dbgData)
    );

endmodule

`default_nettype wire

// File: testbench/ptop_sva.sv
`default_nettype none

module ptopSva (
    input logic clk,
    input logic rstN,
    input logic run,
    input logic loadReady,
    input logic wbValid,
    input rvPkg::wbInfo_t wb
);

    timeunit 1ns;
    timeprecision 1ps;

    logic idleViolated = 1'b0;
    logic readyViolated = 1'b0;
    logic rdViolated = 1'b0;
    logic anyFailed;

    assign anyFailed = idleViolated | readyViolated | rdViolated;

    // Stopped core retires nothing
    stoppedQuiet: assert property (@(posedge clk) disable iff (!rstN) !run |-> !wbValid)
        else begin
            idleViolated = 1'b1;
            $error("wbValid high while run is low");
        end

    readyFollowsRun: assert property (@(posedge clk) loadReady == !run)
        else begin
            readyViolated = 1'b1;
            $error("loadReady is not the inverse of run");
        end

    noTraceForX0: assert property (@(posedge clk) disable iff (!rstN) wbValid |-> wb.rd != '0)
        else begin
            rdViolated = 1'b1;
            $error("Trace entry for register x0");
        end

endmodule

`default_nettype wire

// File: testbench/ptopTb.sv
`default_nettype none

module ptopTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int GOLDEN_DEPTH = 128;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES = 12;

    logic clk = 1'b0;
    logic rstN;
    logic run;
    logic loadValid;
    logic loadReady;
    rvPkg::loadReq_t load;
    logic wbValid;
    rvPkg::wbInfo_t wb;
    rvPkg::regAddr_t dbgAddr;
    rvPkg::word_t dbgData;

    rvPkg::word_t golden [GOLDEN_DEPTH];
    int progLen;
    int traceLen;
    int traceBase;
    int regLen;
    int regBase;
    int unsigned cycleCount = 0;
    int unsigned cycleLimit = 0;
    logic traceDone = 1'b0;

    ptop #(
        .IMEM_WORDS(IMEM_WORDS),
        .DMEM_WORDS(DMEM_WORDS)
    ) i_dut (
        .clk(clk),
        .rstN(rstN),
        .run(run),
        .loadValid(loadValid),
        .loadReady(loadReady),
        .load(load),
        .wbValid(wbValid),
        .wb(wb),
        .dbgAddr(dbgAddr),
        .dbgData(dbgData)
    );

    bind ptop ptopSva i_sva (
        .clk(clk),
        .rstN(rstN),
        .run(run),
        .loadReady(loadReady),
        .wbValid(wbValid),
        .wb(wb)
    );

    always #4 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkWb(input string name, input rvPkg::wbInfo_t expected,
                           input rvPkg::wbInfo_t actual);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch %s: expected x%0d=%h, actual x%0d=%h",
                              name, expected.rd, expected.value, actual.rd, actual.value));
        end
    endtask

    task automatic checkReg(input string name, input rvPkg::regAddr_t addr,
                            input rvPkg::word_t expected, input rvPkg::word_t actual);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch %s: x%0d expected %h, actual %h",
                              name, addr, expected, actual));
        end
    endtask

    task automatic checkReady(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // One word per handshake, held until the accepting edge
    task automatic loadProgram();
        int i;
        logic accepted;
        for (i = 0; i < progLen; i++) begin
            loadValid = 1'b1;
            load.addr = i;
            load.instr = golden[1 + i];
            do begin
                @(negedge clk);
                accepted = loadReady;
                @(posedge clk);
                #1;
            end while (!accepted);
        end
        loadValid = 1'b0;
        load = '0;
    endtask

    task automatic collectTrace();
        int idx;
        rvPkg::wbInfo_t expected;
        idx = 0;
        while (idx < traceLen) begin
            @(negedge clk);
            checkReady("loadReady while running", 1'b0, loadReady);
            if (wbValid) begin
                expected.rd = golden[traceBase + 2 * idx][4:0];
                expected.value = golden[traceBase + 2 * idx + 1];
                checkWb($sformatf("trace entry %0d", idx), expected, wb);
                idx++;
            end
        end
    endtask

    task automatic checkFinalRegs();
        int k;
        for (k = 0; k < regLen; k++) begin
            @(posedge clk);
            #1;
            dbgAddr = golden[regBase + 2 * k][4:0];
            @(negedge clk);
            checkReg("final register", dbgAddr, golden[regBase + 2 * k + 1], dbgData);
        end
    endtask

    // Budget: three cycles per program word plus drain
    always @(posedge clk) begin
        if (rstN && !traceDone) begin
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                failRun($sformatf("Timeout: writeback trace never completed in %0d cycles",
                                  cycleLimit));
            end
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_sva.anyFailed) begin
            failRun("An assertion in ptopSva failed");
        end
    end

    initial begin
        rstN = 1'b0;
        run = 1'b0;
        loadValid = 1'b0;
        load = '0;
        dbgAddr = '0;

        $readmemh("testbench/ptopGolden.txt", golden);
        progLen = golden[0];
        if ($isunknown(golden[0]) || progLen < 1 || progLen > IMEM_WORDS) begin
            failRun("Golden file has no usable program length");
        end
        traceLen = golden[progLen + 1];
        traceBase = progLen + 2;
        regLen = golden[traceBase + 2 * traceLen];
        regBase = traceBase + 2 * traceLen + 1;
        cycleLimit = 3 * progLen + 40;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstN = 1'b1;

        @(negedge clk);
        checkReady("loadReady while stopped", 1'b1, loadReady);
        @(posedge clk);
        #1;
        loadProgram();

        run = 1'b1;
        collectTrace();
        traceDone = 1'b1;

        // Core spins on its final jump with nothing left to retire
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            if (wbValid) begin
                failRun("Unexpected trace entry after the program's final jump");
            end
        end

        checkFinalRegs();

        if (!i_dut.i_sva.anyFailed) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            failRun("An assertion in ptopSva failed");
        end
    end

endmodule

`default_nettype wire

// File: ptop.f
source/rvPkg.sv
source/instrMemory.sv
source/decodeUnit.sv
source/regFile.sv
source/executeUnit.sv
source/hazardUnit.sv
source/dataMemory.sv
source/corePipeline.sv
source/ptop.sv
testbench/ptop_sva.sv
testbench/ptopTb.sv

// File: run.sh
#!/bin/sh
# Builds the ptop testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module ptopTb -f ptop.f -Mdir obj_dir -o ptopSim > build.log 2>&1; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ptopSim +verilator+error+limit+100 > sim.log 2>&1
simStatus=$?
cat sim.log
if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// File: testbench/ptopGolden.txt
// Word count of the program, then the program words (address 0 first)
// Then trace count and rd/value pairs, then final register count and rd/value pairs
00000018
00500093 ffd00113 002081b3 40118233  // addi x1 5, addi x2 -3, add, sub
001272b3 0032e333 004343b3 00112433  // and, or, xor, slt x8
0020a4b3 00702423 00802503 01050593  // slt x9, sw 8(x0), lw 8(x0), addi x11 after load
00208463 06400613 00630663 00100693  // beq not taken, addi x12, beq taken, skipped
00200713 00c007ef 00300813 00400893  // skipped, jal x15, skipped, skipped
00c78933 0000006f 00000013 00000013  // add x18, jal x0 to itself, padding nops
// Writeback trace in program order
0000000e
01 00000005  02 fffffffd  03 00000002  04 fffffffd
05 00000005  06 00000007  07 fffffffa  08 00000001
09 00000000  0a fffffffa  0b 0000000a  0c 00000064
0f 00000048  12 000000ac
// Final register values read through the debug port
0000000f
00 00000000  01 00000005  02 fffffffd  03 00000002
04 fffffffd  05 00000005  06 00000007  07 fffffffa
08 00000001  09 00000000  0a fffffffa  0b 0000000a
0c 00000064  0f 00000048  12 000000ac
